// File: udp_tx.f
+incdir+verification
src/net_pkg.sv
src/frame_pkg.sv
src/tx_header_gen.sv
src/hdr_prepend.sv
src/frame_serializer.sv
src/udp_tx_top.sv
verification/udp_tx_assertions.sv
verification/udp_tx_tb.sv

// File: Makefile
# Verilator build for the udp frame sender testbench

TOP = udp_tx_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f udp_tx.f \
		--top-module $(TOP) -Mdir obj_dir

# pass only when the pass message shows up in the output
run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -F "=== PASS ===" > /dev/null

clean:
	rm -rf obj_dir

// File: verification/udp_tx_ref.svh
/*
 * reference model for the udp sender testbench
 * crc-32, ipv4 header checksum and the expected on-wire byte stream
 */
`ifndef UDP_TX_REF_SVH
`define UDP_TX_REF_SVH

// reflected crc-32 with all-ones init and inverted result
function automatic logic [31:0] fcs_crc32(input byte_t b[$]);
  logic [31:0] c;
  c = 32'hFFFF_FFFF;
  foreach (b[i]) begin
    c = c ^ {24'h0, b[i]};
    for (int k = 0; k < 8; k++) begin
      c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
    end
  end
  return ~c;
endfunction

// ones' complement of the ones' complement sum of ten words
function automatic logic [15:0] ip_hdr_csum(input logic [159:0] h);
  logic [31:0] s;
  s = 0;
  for (int i = 0; i < 10; i++) begin
    s = s + {16'h0, h[159 - 16*i -: 16]};
  end
  while (s[31:16] != 0) begin
    s = {16'h0, s[15:0]} + {16'h0, s[31:16]};
  end
  return ~s[15:0];
endfunction

// ---------------------------------------------------------------------
// full frame with preamble, headers, payload, pad and fcs
// ---------------------------------------------------------------------
function automatic void expected_frame(input mac_addr_t dmac, input ip_addr_t dip,
                                       input udp_port_t dport, input byte_t pay[$],
                                       input logic [15:0] ident, output byte_t q[$]);
  logic [335:0] h;
  logic [15:0]  plen;
  logic [31:0]  fcs;
  byte_t        body[$];
  plen = 16'(pay.size());
  // checksum field starts as zero and is filled below
  h = {dmac, LOCAL_MAC, 16'h0800,
       8'h45, 8'h00, plen + 16'd28, ident, 16'h4000, IP_TTL, PROTO_UDP, 16'h0,
       LOCAL_IP, dip,
       LOCAL_PORT, dport, plen + 16'd8, 16'h0};
  // ip header sits at bytes 14..33, checksum at bytes 24..25
  h[143 -: 16] = ip_hdr_csum(h[223 -: 160]);
  q = {};
  for (int k = 0; k < 7; k++) begin
    q.push_back(8'h55);
  end
  q.push_back(8'hD5);
  for (int k = 0; k < 42; k++) begin
    body.push_back(h[335 - 8*k -: 8]);
  end
  foreach (pay[k]) begin
    body.push_back(pay[k]);
  end
  while (body.size() < 60) begin
    body.push_back(8'h00);
  end
  fcs = fcs_crc32(body);
  foreach (body[k]) begin
    q.push_back(body[k]);
  end
  for (int k = 0; k < 4; k++) begin
    q.push_back(fcs[8*k +: 8]);
  end
endfunction

`endif

// File: verification/udp_tx_tb.sv
/*
 * testbench for the udp frame sender
 * table driven requests, payload source, nibble capture,
 * byte and timing checks against the reference model
 */
`timescale 1ns/10ps
`default_nettype none

module udp_tx_tb
  import net_pkg::*;
;

  localparam mac_addr_t LOCAL_MAC  = 48'h02_12_34_56_78_9A;
  localparam ip_addr_t  LOCAL_IP   = {8'd10, 8'd0, 8'd0, 8'd2};
  localparam udp_port_t LOCAL_PORT = 16'd5000;
  localparam int        N_TESTS    = 9;

  `include "udp_tx_ref.svh"

  // b2b marks a request queued while the previous frame is on the wire
  typedef struct {
    string     name;
    mac_addr_t mac;
    ip_addr_t  ip;
    udp_port_t port;
    int        len;
    int        pay_seed;
    bit        b2b;
  } test_t;

  logic        tx_clock = 1'b0;
  logic        arst_n;
  logic        tx_request;
  udp_tx_req_t tx_req;
  byte_t       payload_data;
  logic        tx_busy;
  logic        payload_rd;
  logic [3:0]  phy_txd;
  logic        phy_tx_en;

  test_t tests [N_TESTS];
  byte_t pay_mem [N_TESTS][MAX_PAYLOAD];
  int    seed;
  int    errors = 0;
  int    failed = 0;

  // monitor state
  int          cyc = 0;
  int          acc_cnt = 0;
  int          acc_cyc = 0;
  int          cur_test = 0;
  int          pidx = 0;
  int          fall_cyc = 0;
  int          en_high = 0;
  int          done_cnt = 0;
  int          nfr = 0;
  int          tst_err = 0;
  logic        en_q = 1'b0;
  logic        busy_q = 1'b0;
  logic        nib_hi = 1'b0;
  logic [3:0]  lo_nib;
  logic [15:0] prev_id;
  byte_t       got[$];

  udp_tx_top #(
    .LOCAL_MAC  (LOCAL_MAC),
    .LOCAL_IP   (LOCAL_IP),
    .LOCAL_PORT (LOCAL_PORT)
  ) UUT (
    .tx_clock     (tx_clock),
    .arst_n       (arst_n),
    .tx_request   (tx_request),
    .tx_req       (tx_req),
    .payload_data (payload_data),
    .tx_busy      (tx_busy),
    .payload_rd   (payload_rd),
    .phy_txd      (phy_txd),
    .phy_tx_en    (phy_tx_en)
  );

  always #50 tx_clock = ~tx_clock;

  // frame body bytes before the fcs
  function automatic int body_len(input int len);
    return (42 + len < 60) ? 60 : 42 + len;
  endfunction

  // ---------------------------------------------------------------------
  // frame content checks when tx_en falls
  // ---------------------------------------------------------------------
  task automatic check_frame(input int t);
    byte_t       pay[$];
    byte_t       exp[$];
    int          nbad;
    int          first;
    logic [15:0] id;
    nbad = 0;
    first = 0;
    for (int k = 0; k < tests[t].len; k++) begin
      pay.push_back(pay_mem[t][k]);
    end
    expected_frame(tests[t].mac, tests[t].ip, tests[t].port, pay, 16'(nfr), exp);
    assert (got.size() == exp.size()) else begin
      $display("FAIL %s frame bytes expected %0d actual %0d",
               tests[t].name, exp.size(), got.size());
      tst_err++;
    end
    for (int k = 0; k < exp.size() && k < got.size(); k++) begin
      if (got[k] !== exp[k]) begin
        if (nbad == 0) begin
          first = k;
        end
        nbad++;
      end
    end
    assert (nbad == 0) else begin
      $display("FAIL %s byte %0d expected %02h actual %02h (%0d bad)",
               tests[t].name, first, exp[first], got[first], nbad);
      tst_err++;
    end
    assert (en_high == 2 * (8 + body_len(tests[t].len) + 4)) else begin
      $display("FAIL %s tx_en cycles expected %0d actual %0d", tests[t].name,
               2 * (8 + body_len(tests[t].len) + 4), en_high);
      tst_err++;
    end
    // identification sits at wire bytes 26..27
    if (got.size() > 27) begin
      id = {got[26], got[27]};
      if (nfr > 0) begin
        assert (id == prev_id + 16'd1) else begin
          $display("FAIL %s ident expected %04h actual %04h",
                   tests[t].name, prev_id + 16'd1, id);
          tst_err++;
        end
      end
      prev_id = id;
    end
  endtask

  // ---------------------------------------------------------------------
  // monitor sampling dut outputs as they were before each edge
  // ---------------------------------------------------------------------
  always @(posedge tx_clock) begin
    if (arst_n) begin
      cyc++;
      // busy fall closes the test before a new accept can take over
      if (!tx_busy && busy_q) begin
        assert (cyc - fall_cyc == 24) else begin
          $display("FAIL %s busy after tx_en expected %0d actual %0d",
                   tests[cur_test].name, 24, cyc - fall_cyc);
          tst_err++;
        end
        if (tst_err == 0) begin
          $display("ok    %s", tests[cur_test].name);
        end else begin
          $display("bad   %s: %0d errors", tests[cur_test].name, tst_err);
          failed++;
        end
        errors += tst_err;
        done_cnt++;
      end
      if (tx_request && !tx_busy) begin
        acc_cyc = cyc;
        cur_test = acc_cnt;
        acc_cnt++;
        pidx = 0;
      end else if (payload_rd) begin
        pidx++;
      end
      if (phy_tx_en && !en_q) begin
        tst_err = 0;
        en_high = 0;
        nib_hi = 1'b0;
        got = {};
        assert (cyc - 1 - acc_cyc == 2) else begin
          $display("FAIL %s tx_en after accept expected %0d actual %0d",
                   tests[cur_test].name, 2, cyc - 1 - acc_cyc);
          tst_err++;
        end
        // busy drop, one accept edge, two cycles to tx_en
        if (tests[cur_test].b2b) begin
          assert (cyc - fall_cyc == 24 + 1 + 2) else begin
            $display("FAIL %s frame gap expected %0d actual %0d",
                     tests[cur_test].name, 27, cyc - fall_cyc);
            tst_err++;
          end
        end
      end
      if (phy_tx_en) begin
        en_high++;
        if (!nib_hi) begin
          lo_nib = phy_txd;
        end else begin
          got.push_back({phy_txd, lo_nib});
        end
        nib_hi = !nib_hi;
      end
      if (!phy_tx_en && en_q) begin
        fall_cyc = cyc;
        check_frame(cur_test);
        nfr++;
      end
      en_q = phy_tx_en;
      busy_q = tx_busy;
    end
  end

  // host payload source moves to the next byte after each read
  always @(negedge tx_clock) begin
    if (pidx < tests[cur_test].len && pidx < MAX_PAYLOAD) begin
      payload_data = pay_mem[cur_test][pidx];
    end else begin
      payload_data = 8'h00;
    end
  end

  // watchdog over total frame time plus margin
  initial begin
    int limit;
    @(posedge arst_n);
    limit = 200;
    for (int t = 0; t < N_TESTS; t++) begin
      limit += 2 * (8 + body_len(tests[t].len) + 4) + 24 + 10;
    end
    while (cyc <= limit) @(posedge tx_clock);
    $display("timeout: frames not finished after %0d cycles", limit);
    $display("=== FAIL ===");
    $finish;
  end

  // ---------------------------------------------------------------------
  // stimulus
  // ---------------------------------------------------------------------
  initial begin
    tests[0] = '{"pad_len0",  48'h00_11_22_33_44_55, 32'h0A00_0001, 16'd7,    0,   1, 1'b0};
    tests[1] = '{"pad_len1",  48'h00_11_22_33_44_56, 32'h0A00_0003, 16'd53,   1,   2, 1'b0};
    tests[2] = '{"pad_len17", 48'hA0_B1_C2_D3_E4_F5, 32'hC0A8_0105, 16'd8080, 17,  3, 1'b0};
    tests[3] = '{"len18",     48'hFF_FF_FF_FF_FF_FF, 32'hFFFF_FFFF, 16'd9,    18,  4, 1'b0};
    tests[4] = '{"len100",    48'h3C_97_0E_12_34_56, 32'hAC10_2030, 16'd4660, 100, 5, 1'b0};
    tests[5] = '{"len_max",   48'h00_1B_21_AA_BB_CC, 32'h0A01_0203, 16'd65535,
                 MAX_PAYLOAD, 6, 1'b0};
    tests[6] = '{"b2b_first", 48'h00_00_00_00_00_01, 32'h0A00_0010, 16'd1000, 40,  7, 1'b0};
    tests[7] = '{"b2b_next",  48'h00_00_00_00_00_02, 32'h0A00_0011, 16'd1001, 64,  8, 1'b1};
    tests[8] = '{"b2b_last",  48'h00_00_00_00_00_03, 32'h0A00_0012, 16'd1002, 5,   9, 1'b1};
    for (int t = 0; t < N_TESTS; t++) begin
      seed = 91 ^ tests[t].pay_seed;
      for (int k = 0; k < tests[t].len; k++) begin
        pay_mem[t][k] = 8'($random(seed));
      end
    end
    arst_n = 1'b0;
    tx_request = 1'b0;
    tx_req = '0;
    payload_data = 8'h00;
    repeat (3) @(negedge tx_clock);
    arst_n = 1'b1;
    @(negedge tx_clock);
    assert (!tx_busy && !phy_tx_en && !payload_rd && phy_txd == 4'h0) else begin
      $display("FAIL reset busy/en/rd/txd expected 0/0/0/0 actual %b/%b/%b/%h",
               tx_busy, phy_tx_en, payload_rd, phy_txd);
      errors++;
      failed++;
    end
    $display("%s  reset", (errors == 0) ? "ok  " : "bad ");
    for (int i = 0; i < N_TESTS; i++) begin
      if (!tests[i].b2b) begin
        while (tx_busy) @(negedge tx_clock);
      end
      @(negedge tx_clock);
      tx_req.dst_mac = tests[i].mac;
      tx_req.dst_ip = tests[i].ip;
      tx_req.dst_port = tests[i].port;
      tx_req.payload_len = 16'(tests[i].len);
      tx_request = 1'b1;
      while (acc_cnt <= i) @(negedge tx_clock);
      // keep the request up when the next one queues behind this frame
      if (!(i + 1 < N_TESTS && tests[i + 1].b2b)) begin
        tx_request = 1'b0;
      end
    end
    while (done_cnt < N_TESTS) @(negedge tx_clock);
    $display("tests %0d, failed %0d, errors %0d", N_TESTS + 1, failed, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/udp_tx_assertions.sv
/*
 * bound checks on the udp sender top level
 * enable inside busy, payload read spacing, idle data lines
 */
`timescale 1ns/10ps
`default_nettype none

module udp_tx_assertions (
  input wire       tx_clock,
  input wire       arst_n,
  input wire       tx_busy,
  input wire       payload_rd,
  input wire       phy_tx_en,
  input wire [3:0] phy_txd
);

  // frame only on the wire while a request is owned
  en_within_busy: assert property (@(posedge tx_clock) disable iff (!arst_n)
    phy_tx_en |-> tx_busy)
    else $error("phy_tx_en high while tx_busy is low");

  // one byte per two nibbles
  rd_spacing: assert property (@(posedge tx_clock) disable iff (!arst_n)
    payload_rd |=> !payload_rd)
    else $error("payload_rd on two consecutive cycles");

  idle_txd_zero: assert property (@(posedge tx_clock) disable iff (!arst_n)
    !phy_tx_en |-> (phy_txd == 4'h0))
    else $error("phy_txd not zero while phy_tx_en is low");

endmodule

bind udp_tx_top udp_tx_assertions u_assertions (.*);

`default_nettype wire

// File: src/udp_tx_top.sv
/*
 * udp transmit top
 * header generator, three header inserters and the nibble serializer
 */
`timescale 1ns/10ps
`default_nettype none

module udp_tx_top
  import net_pkg::*, frame_pkg::*;
#(
  parameter mac_addr_t LOCAL_MAC  = 48'h02_00_5E_10_00_01,
  parameter ip_addr_t  LOCAL_IP   = {8'd192, 8'd168, 8'd1, 8'd20},
  parameter udp_port_t LOCAL_PORT = 16'd1024
) (
  input  wire              tx_clock,
  input  wire              arst_n,
  input  wire              tx_request,
  input  wire udp_tx_req_t tx_req,
  input  wire byte_t       payload_data,
  output logic             tx_busy,
  output logic             payload_rd,
  output logic [3:0]       phy_txd,
  output logic             phy_tx_en
);

  logic      frame_start;
  logic      frame_done;
  udp_hdr_t  udp_hdr;
  ipv4_hdr_t ip_hdr;
  eth_hdr_t  eth_hdr;

  // byte chain with read strobes running upstream
  logic  eth_rd;
  logic  ip_rd;
  logic  udp_rd;
  byte_t eth_data;
  byte_t ip_data;
  byte_t udp_data;

  tx_header_gen #(
    .LOCAL_MAC  (LOCAL_MAC),
    .LOCAL_IP   (LOCAL_IP),
    .LOCAL_PORT (LOCAL_PORT)
  ) u_hdr_gen (
    .tx_clock    (tx_clock),
    .arst_n      (arst_n),
    .tx_request  (tx_request),
    .tx_req      (tx_req),
    .frame_done  (frame_done),
    .tx_busy     (tx_busy),
    .frame_start (frame_start),
    .udp_hdr     (udp_hdr),
    .ip_hdr      (ip_hdr),
    .eth_hdr     (eth_hdr)
  );

  // innermost stage pulls the host payload
  hdr_prepend #(.hdr_t(udp_hdr_t)) u_udp_ins (
    .tx_clock    (tx_clock),
    .arst_n      (arst_n),
    .frame_start (frame_start),
    .hdr         (udp_hdr),
    .rd          (udp_rd),
    .up_data     (payload_data),
    .data        (udp_data),
    .up_rd       (payload_rd)
  );

  hdr_prepend #(.hdr_t(ipv4_hdr_t)) u_ip_ins (
    .tx_clock    (tx_clock),
    .arst_n      (arst_n),
    .frame_start (frame_start),
    .hdr         (ip_hdr),
    .rd          (ip_rd),
    .up_data     (udp_data),
    .data        (ip_data),
    .up_rd       (udp_rd)
  );

  hdr_prepend #(.hdr_t(eth_hdr_t)) u_eth_ins (
    .tx_clock    (tx_clock),
    .arst_n      (arst_n),
    .frame_start (frame_start),
    .hdr         (eth_hdr),
    .rd          (eth_rd),
    .up_data     (ip_data),
    .data        (eth_data),
    .up_rd       (ip_rd)
  );

  // payload length recovered from the held udp length
  frame_serializer u_ser (
    .tx_clock    (tx_clock),
    .arst_n      (arst_n),
    .frame_start (frame_start),
    .payload_len (udp_hdr.udp_len - 16'(UDP_HDR_BYTES)),
    .data        (eth_data),
    .rd          (eth_rd),
    .frame_done  (frame_done),
    .phy_txd     (phy_txd),
    .phy_tx_en   (phy_tx_en)
  );

endmodule

`default_nettype wire

// File: src/frame_serializer.sv
/*
 * frame serializer
 * preamble, body pull, zero padding, crc-32 fcs and interframe gap,
 * sent as 4-bit symbols low nibble first with transmit enable
 */
`timescale 1ns/10ps
`default_nettype none

module frame_serializer
  import net_pkg::*, frame_pkg::*;
(
  input  wire        tx_clock,
  input  wire        arst_n,
  input  wire        frame_start,
  input  wire [15:0] payload_len,
  input  wire byte_t data,
  output logic       rd,
  output logic       frame_done,
  output logic [3:0] phy_txd,
  output logic       phy_tx_en
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_PRE,
    ST_BODY,
    ST_PAD,
    ST_FCS,
    ST_GAP
  } phase_t;

  // last byte index of each phase
  localparam logic [15:0] PRE_LAST = 16'(PREAMBLE_BYTES - 1);
  localparam logic [15:0] MIN_LAST = 16'(MIN_FRAME_BYTES - 1);
  localparam logic [15:0] FCS_LAST = 16'd3;
  localparam logic [15:0] GAP_LAST = 16'(IFG_BYTES - 1);
  localparam byte_t       PRE_BYTE = 8'h55;
  localparam byte_t       SFD_BYTE = 8'hD5;

  phase_t      state;
  // 0 on the low nibble cycle, 1 on the high one
  logic        half;
  logic [15:0] cnt;
  logic [15:0] body_last;
  logic [31:0] crc;
  byte_t       hold;
  byte_t       byte_now;
  logic        on_air;

  // one byte through the reflected crc lsb first
  function automatic logic [31:0] crc_byte(input logic [31:0] c, input byte_t d);
    logic [31:0] r;
    r = c;
    for (int i = 0; i < 8; i++) begin
      r = (r >> 1) ^ (CRC32_POLY & {32{r[0] ^ d[i]}});
    end
    return r;
  endfunction

  // ------------------------------------------------------------------
  // byte source per phase
  // ------------------------------------------------------------------
  always_comb begin
    case (state)
      ST_PRE:  byte_now = (cnt == PRE_LAST) ? SFD_BYTE : PRE_BYTE;
      ST_BODY: byte_now = data;
      // inverted crc goes out low byte first
      ST_FCS:  byte_now = ~crc[8*cnt[1:0] +: 8];
      default: byte_now = '0;
    endcase
  end

  assign on_air = (state == ST_PRE) || (state == ST_BODY) ||
                  (state == ST_PAD) || (state == ST_FCS);

  // one pull per byte time on the low nibble cycle
  assign rd = (state == ST_BODY) && !half;

  // ------------------------------------------------------------------
  // phase fsm advancing at the end of each byte time
  // ------------------------------------------------------------------
  always_ff @(posedge tx_clock or negedge arst_n) begin
    if (!arst_n) begin
      state      <= ST_IDLE;
      half       <= 1'b0;
      cnt        <= '0;
      frame_done <= 1'b0;
    end else begin
      frame_done <= 1'b0;
      if (state == ST_IDLE) begin
        half <= 1'b0;
        cnt  <= '0;
        if (frame_start) begin
          state <= ST_PRE;
        end
      end else begin
        half <= ~half;
        if (half) begin
          cnt <= cnt + 16'd1;
          case (state)
            ST_PRE: begin
              if (cnt == PRE_LAST) begin
                state <= ST_BODY;
                cnt   <= '0;
              end
            end
            ST_BODY: begin
              if (cnt == body_last) begin
                // short frame keeps counting into the pad
                if (cnt < MIN_LAST) begin
                  state <= ST_PAD;
                end else begin
                  state <= ST_FCS;
                  cnt   <= '0;
                end
              end
            end
            ST_PAD: begin
              if (cnt == MIN_LAST) begin
                state <= ST_FCS;
                cnt   <= '0;
              end
            end
            ST_FCS: begin
              if (cnt == FCS_LAST) begin
                state <= ST_GAP;
                cnt   <= '0;
              end
            end
            ST_GAP: begin
              if (cnt == GAP_LAST) begin
                state      <= ST_IDLE;
                frame_done <= 1'b1;
              end
            end
            default: state <= ST_IDLE;
          endcase
        end
      end
    end
  end

  // frame length, byte hold and running crc
  always_ff @(posedge tx_clock) begin
    if (frame_start) begin
      body_last <= payload_len + 16'(HDR_TOTAL_BYTES - 1);
      crc       <= 32'hFFFF_FFFF;
    end
    if (!half) begin
      hold <= byte_now;
      // crc covers body and pad, not preamble
      if ((state == ST_BODY) || (state == ST_PAD)) begin
        crc <= crc_byte(crc, byte_now);
      end
    end
  end

  // ------------------------------------------------------------------
  // registered phy outputs
  // ------------------------------------------------------------------
  always_ff @(posedge tx_clock or negedge arst_n) begin
    if (!arst_n) begin
      phy_tx_en <= 1'b0;
      phy_txd   <= '0;
    end else begin
      phy_tx_en <= on_air;
      if (!on_air) begin
        phy_txd <= '0;
      end else if (half) begin
        phy_txd <= hold[7:4];
      end else begin
        phy_txd <= byte_now[3:0];
      end
    end
  end

endmodule

`default_nettype wire

// File: src/hdr_prepend.sv
/*
 * header inserter
 * answers reads from a stored header, msb first,
 * then forwards reads and data to the upstream stage
 */
`timescale 1ns/10ps
`default_nettype none

module hdr_prepend
  import net_pkg::*;
#(
  parameter type hdr_t = logic [63:0]
) (
  input  wire        tx_clock,
  input  wire        arst_n,
  input  wire        frame_start,
  input  wire hdr_t  hdr,
  input  wire        rd,
  input  wire byte_t up_data,
  output byte_t      data,
  output logic       up_rd
);

  localparam int HDR_BYTES = $bits(hdr_t) / 8;
  localparam int IDX_W     = $clog2(HDR_BYTES + 1);
  // index value once all header bytes are out
  localparam logic [IDX_W-1:0] HDR_END = IDX_W'(HDR_BYTES);

  logic [HDR_BYTES-1:0][7:0] hdr_q;
  logic [IDX_W-1:0]          idx;
  logic                      hdr_done;

  assign hdr_done = (idx == HDR_END);

  // header snapshot at frame start
  always_ff @(posedge tx_clock) begin
    if (frame_start) begin
      hdr_q <= hdr;
    end
  end

  // byte index parks at the end between frames
  always_ff @(posedge tx_clock or negedge arst_n) begin
    if (!arst_n) begin
      idx <= HDR_END;
    end else if (frame_start) begin
      idx <= '0;
    end else if (rd && !hdr_done) begin
      idx <= idx + IDX_W'(1);
    end
  end

  // ------------------------------------------------------------------
  // read path
  // ------------------------------------------------------------------
  always_comb begin
    if (hdr_done) begin
      data = up_data;
    end else begin
      // byte 0 is the top byte of the struct
      data = hdr_q[HDR_BYTES - 1 - int'(idx)];
    end
  end

  // upstream only sees reads past the header
  assign up_rd = rd && hdr_done;

endmodule

`default_nettype wire

// File: src/tx_header_gen.sv
/*
 * tx header generator
 * accepts a host request, builds udp, ipv4 and ethernet headers
 * with the ipv4 checksum, and holds busy until the frame is done
 */
`timescale 1ns/10ps
`default_nettype none

module tx_header_gen
  import net_pkg::*, frame_pkg::*;
#(
  parameter mac_addr_t LOCAL_MAC  = 48'h0,
  parameter ip_addr_t  LOCAL_IP   = 32'h0,
  parameter udp_port_t LOCAL_PORT = 16'h0
) (
  input  wire              tx_clock,
  input  wire              arst_n,
  input  wire              tx_request,
  input  wire udp_tx_req_t tx_req,
  input  wire              frame_done,
  output logic             tx_busy,
  output logic             frame_start,
  output udp_hdr_t         udp_hdr,
  output ipv4_hdr_t        ip_hdr,
  output eth_hdr_t         eth_hdr
);

  udp_tx_req_t req_q;
  logic [15:0] ident_q;
  logic        accept;
  ipv4_hdr_t   ip_base;

  // ones' complement sum over the header, checksum field zero
  function automatic logic [15:0] ip_checksum(input ipv4_hdr_t h);
    logic [31:0] sum;
    sum = '0;
    for (int i = 0; i < IPV4_HDR_BYTES / 2; i++) begin
      sum = sum + 32'(h[16*i +: 16]);
    end
    // second fold catches the carry of the first
    sum = 32'(sum[15:0]) + 32'(sum[31:16]);
    sum = 32'(sum[15:0]) + 32'(sum[31:16]);
    return ~sum[15:0];
  endfunction

  // one request at a time
  assign accept = tx_request && !tx_busy;

  // ------------------------------------------------------------------
  // handshake and frame counter
  // ------------------------------------------------------------------
  always_ff @(posedge tx_clock or negedge arst_n) begin
    if (!arst_n) begin
      tx_busy     <= 1'b0;
      frame_start <= 1'b0;
      ident_q     <= '0;
    end else begin
      frame_start <= accept;
      if (accept) begin
        tx_busy <= 1'b1;
      end else if (frame_done) begin
        tx_busy <= 1'b0;
      end
      // inserters have taken the headers by now
      if (frame_start) begin
        ident_q <= ident_q + 16'd1;
      end
    end
  end

  // request latch stays stable until the next acceptance
  always_ff @(posedge tx_clock) begin
    if (accept) begin
      req_q <= tx_req;
    end
  end

  // ------------------------------------------------------------------
  // header fields
  // ------------------------------------------------------------------
  always_comb begin
    udp_hdr          = '0;
    udp_hdr.src_port = LOCAL_PORT;
    udp_hdr.dst_port = req_q.dst_port;
    udp_hdr.udp_len  = req_q.payload_len + 16'(UDP_HDR_BYTES);
  end

  always_comb begin
    ip_base           = '0;
    ip_base.version   = 4'd4;
    // ihl in 32-bit words
    ip_base.ihl       = 4'(IPV4_HDR_BYTES / 4);
    ip_base.total_len = req_q.payload_len + 16'(IPV4_HDR_BYTES + UDP_HDR_BYTES);
    ip_base.ident     = ident_q;
    // don't fragment
    ip_base.flags     = 3'b010;
    ip_base.ttl       = IP_TTL;
    ip_base.protocol  = PROTO_UDP;
    ip_base.src_ip    = LOCAL_IP;
    ip_base.dst_ip    = req_q.dst_ip;
  end

  always_comb begin
    ip_hdr          = ip_base;
    ip_hdr.checksum = ip_checksum(ip_base);
  end

  always_comb begin
    eth_hdr.dst_mac   = req_q.dst_mac;
    eth_hdr.src_mac   = LOCAL_MAC;
    eth_hdr.ethertype = ETHERTYPE_IPV4;
  end

endmodule

`default_nettype wire

// File: src/frame_pkg.sv
/*
 * frame layout package
 * packed udp, ipv4 and ethernet headers in wire order,
 * msb of each struct goes out first
 */
`default_nettype none

package frame_pkg;
  import net_pkg::*;

  // udp header, 8 bytes
  typedef struct packed {
    udp_port_t   src_port;
    udp_port_t   dst_port;
    logic [15:0] udp_len;
    // zero means no checksum
    logic [15:0] checksum;
  } udp_hdr_t;

  // ipv4 header, 20 bytes, no options
  typedef struct packed {
    logic [3:0]  version;
    logic [3:0]  ihl;
    logic [7:0]  tos;
    logic [15:0] total_len;
    logic [15:0] ident;
    logic [2:0]  flags;
    logic [12:0] frag_off;
    logic [7:0]  ttl;
    logic [7:0]  protocol;
    logic [15:0] checksum;
    ip_addr_t    src_ip;
    ip_addr_t    dst_ip;
  } ipv4_hdr_t;

  // ethernet ii header, 14 bytes
  typedef struct packed {
    mac_addr_t   dst_mac;
    mac_addr_t   src_mac;
    logic [15:0] ethertype;
  } eth_hdr_t;

  localparam int UDP_HDR_BYTES   = $bits(udp_hdr_t) / 8;
  localparam int IPV4_HDR_BYTES  = $bits(ipv4_hdr_t) / 8;
  localparam int ETH_HDR_BYTES   = $bits(eth_hdr_t) / 8;
  // header bytes ahead of the payload, 42
  localparam int HDR_TOTAL_BYTES = UDP_HDR_BYTES + IPV4_HDR_BYTES + ETH_HDR_BYTES;

  // reflected ieee 802.3 polynomial
  localparam logic [31:0] CRC32_POLY = 32'hEDB8_8320;

endpackage

`default_nettype wire

// File: src/net_pkg.sv
/*
 * network package
 * address types, frame size constants and the host request
 * for the udp frame sender
 */
`default_nettype none

package net_pkg;

  // ------------------------------------------------------------------
  // address and data types
  // ------------------------------------------------------------------
  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] ip_addr_t;
  typedef logic [15:0] udp_port_t;
  typedef logic [7:0]  byte_t;

  // protocol codes
  localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
  localparam logic [7:0]  IP_TTL         = 8'd128;
  localparam logic [7:0]  PROTO_UDP      = 8'd17;

  // sizes in bytes
  // min frame excludes the fcs
  localparam int MIN_FRAME_BYTES = 60;
  // 7 x 0x55 plus the sfd
  localparam int PREAMBLE_BYTES  = 8;
  localparam int IFG_BYTES       = 12;
  localparam int MAX_PAYLOAD     = 1472;

  // one host request, held until busy is seen
  typedef struct packed {
    mac_addr_t   dst_mac;
    ip_addr_t    dst_ip;
    udp_port_t   dst_port;
    logic [15:0] payload_len;
  } udp_tx_req_t;

endpackage

`default_nettype wire
